/* include/memCtl_settings.svh */
`ifndef MEMCTL_SETTINGS_SVH
`define MEMCTL_SETTINGS_SVH

// Microcode field widths
`define MEM_W 4
`define MAGIC_W 9
`define DRMA_W 3

// Request address with the section at its top
`define ADDR_W 24
`define SECT_W 6
`define MAX_SECTION 31

// Request flag vectors
`define CYC_W 5
`define CTX_W 4

`endif

/* logic/uCodePkg.sv */
`include "memCtl_settings.svh"

package uCodePkg;

  typedef logic [`MEM_W-1:0] memField_t;
  typedef logic [`MAGIC_W-1:0] magic_t;
  typedef logic [`DRMA_W-1:0] drmA_t;

  // Value is the memory field itself
  typedef enum logic [`MEM_W-1:0] {
    none        = 4'd0,
    regFunc     = 4'd1,
    condFetch   = 4'd2,
    bWrite      = 4'd3,
    aRead       = 4'd4,
    restoreVma  = 4'd5,
    mbWait      = 4'd6,
    arlInd      = 4'd7,
    adFunc      = 4'd8,
    eaCalc      = 4'd9,
    loadAr      = 4'd10,
    loadArx     = 4'd11,
    rwCycle     = 4'd12,
    rpwCycle    = 4'd13,
    write       = 4'd14,
    uncondFetch = 4'd15
  } memFunc_e;

  // Magic bits with a fixed meaning here
  localparam int MAGIC_COND = 5;
  localparam int MAGIC_PREV = 5;

endpackage

/* logic/memReqPkg.sv */
`include "memCtl_settings.svh"

package memReqPkg;

  typedef logic [`ADDR_W-1:0] addr_t;
  typedef logic [`SECT_W-1:0] section_t;

  // {loadAr, loadArx, pause, write, fetch}
  typedef logic [`CYC_W-1:0] cycFlags_t;
  // {user, public, previous, extended}
  typedef logic [`CTX_W-1:0] ctxFlags_t;

  localparam int CYC_LOAD_AR = 4;
  localparam int CYC_LOAD_ARX = 3;
  localparam int CYC_PAUSE = 2;
  localparam int CYC_WRITE = 1;
  localparam int CYC_FETCH = 0;

  localparam int CTX_USER = 3;
  localparam int CTX_PUBLIC = 2;
  localparam int CTX_PREVIOUS = 1;
  localparam int CTX_EXTENDED = 0;

endpackage

/* logic/memFuncDecode.sv */
`timescale 1ns/1ps

module memFuncDecode
  import uCodePkg::*;
  import memReqPkg::*;
(
  input  memField_t stepMem,
  input  magic_t    stepMagic,
  input  drmA_t     stepDrmA,
  output memFunc_e  func,
  output cycFlags_t cycNext
);

  assign func = memFunc_e'(stepMem);

  always_comb begin
    logic [3:0] eaBits;
    logic isARead;
    logic aRead367;
    logic rwOrRpw;
    logic fetchEn;

    // EA calc lets magic 3..0 request a cycle directly
    eaBits = (func == eaCalc) ? stepMagic[3:0] : 4'b0000;
    isARead = (func == aRead);
    aRead367 = isARead &
               (stepDrmA == 3'd3 || stepDrmA == 3'd6 || stepDrmA == 3'd7);
    rwOrRpw = (func == rwCycle) || (func == rpwCycle);

    fetchEn = (func == uncondFetch) ||
              ((func == condFetch) && stepMagic[MAGIC_COND]);

    cycNext = '0;
    cycNext[CYC_FETCH] = fetchEn;
    cycNext[CYC_LOAD_AR] = (func == loadAr) || rwOrRpw ||
                           (isARead && stepDrmA[2]) || eaBits[3];
    cycNext[CYC_LOAD_ARX] = (func == loadArx) || fetchEn || eaBits[2];
    cycNext[CYC_PAUSE] = (func == rpwCycle) ||
                         (isARead && stepDrmA == 3'd7) || eaBits[1];
    cycNext[CYC_WRITE] = (func == write) || rwOrRpw || (func == bWrite) ||
                         aRead367 || eaBits[0];
  end

endmodule

/* logic/cycleTypeReg.sv */
`timescale 1ns/1ps

module cycleTypeReg
  import memReqPkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      load,
  input  cycFlags_t cycNext,
  output cycFlags_t cyc,
  output logic      hasCycle
);

  // Cycle type of the step last accepted
  always_ff @(posedge clk) begin
    if (rst) begin
      cyc <= '0;
    end else if (load) begin
      cyc <= cycNext;
    end
  end

  // Any flag set means the box must be asked for a cycle
  assign hasCycle = |cyc;

endmodule

/* logic/vmaContext.sv */
`timescale 1ns/1ps
`include "memCtl_settings.svh"

module vmaContext
  import uCodePkg::*;
  import memReqPkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      load,
  input  memFunc_e  func,
  input  magic_t    stepMagic,
  input  addr_t     stepAd,
  input  logic      userMode,
  input  logic      publicMode,
  input  logic      pxctEn,
  input  logic      prevUser,
  output addr_t     reqAddr,
  output ctxFlags_t reqCtx,
  output logic      reqAdrErr
);

  section_t  section;
  ctxFlags_t ctxNext;
  logic      adrErrNext;

  assign section = stepAd[`ADDR_W-1 -: `SECT_W];

  always_comb begin
    logic prevEn;
    logic userEn;
    logic extEn;

    // Previous context only for a PXCT'd EA calc
    prevEn = pxctEn && (func == eaCalc) && stepMagic[MAGIC_PREV];
    userEn = prevEn ? prevUser : userMode;
    extEn = (section != '0) && ((func == eaCalc) || (func == aRead));

    ctxNext = '0;
    ctxNext[CTX_USER] = userEn;
    ctxNext[CTX_PUBLIC] = publicMode && !userEn;
    ctxNext[CTX_PREVIOUS] = prevEn;
    ctxNext[CTX_EXTENDED] = extEn;

    adrErrNext = extEn && (section > section_t'(`MAX_SECTION));
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      reqAddr <= '0;
      reqCtx <= '0;
      reqAdrErr <= 1'b0;
    end else if (load) begin
      reqAddr <= stepAd;
      reqCtx <= ctxNext;
      reqAdrErr <= adrErrNext;
    end
  end

endmodule

/* logic/mboxRequester.sv */
`timescale 1ns/1ps

module mboxRequester
  import memReqPkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       stepValid,
  output logic       stepReady,
  output logic       load,
  input  logic       hasCycle,
  input  cycFlags_t  cyc,
  input  ctxFlags_t  reqCtx,
  input  logic       reqAdrErr,
  output logic       reqValid,
  input  logic       reqReady,
  input  logic [1:0] diagSel,
  output logic [3:0] diagData
);

  logic      stepLoaded;
  logic      reqDone;
  cycFlags_t heldCyc;
  ctxFlags_t heldCtx;
  logic      heldAdrErr;

  // Request is pending while the loaded step still wants a cycle
  assign reqValid = stepLoaded & hasCycle;
  assign reqDone = reqValid & reqReady;
  assign stepReady = ~reqValid | reqReady;
  assign load = stepValid & stepReady;

  always_ff @(posedge clk) begin
    if (rst) begin
      stepLoaded <= 1'b0;
    end else if (load) begin
      stepLoaded <= 1'b1;
    end else if (reqDone) begin
      stepLoaded <= 1'b0;
    end
  end

  // Held copy of the last request taken by the memory box
  always_ff @(posedge clk) begin
    if (rst) begin
      heldCyc <= '0;
      heldCtx <= '0;
      heldAdrErr <= 1'b0;
    end else if (reqDone) begin
      heldCyc <= cyc;
      heldCtx <= reqCtx;
      heldAdrErr <= reqAdrErr;
    end
  end

  always_comb begin
    case (diagSel)
      2'd0: diagData = heldCyc[3:0];
      2'd1: diagData = heldCtx;
      2'd2: diagData = {heldCyc[CYC_FETCH], heldAdrErr, 2'b00};
      default: diagData = 4'b0000;
    endcase
  end

endmodule

/* logic/memCtl.sv */
`timescale 1ns/1ps

module memCtl
  import uCodePkg::*;
  import memReqPkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       stepValid,
  output logic       stepReady,
  input  memField_t  stepMem,
  input  magic_t     stepMagic,
  input  drmA_t      stepDrmA,
  input  addr_t      stepAd,
  input  logic       userMode,
  input  logic       publicMode,
  input  logic       pxctEn,
  input  logic       prevUser,
  output logic       reqValid,
  input  logic       reqReady,
  output addr_t      reqAddr,
  output cycFlags_t  reqCyc,
  output ctxFlags_t  reqCtx,
  output logic       reqAdrErr,
  input  logic [1:0] diagSel,
  output logic [3:0] diagData
);

  memFunc_e  func;
  cycFlags_t cycNext;
  logic      load;
  logic      hasCycle;

  memFuncDecode uDecode (
    .stepMem  (stepMem),
    .stepMagic(stepMagic),
    .stepDrmA (stepDrmA),
    .func     (func),
    .cycNext  (cycNext)
  );

  cycleTypeReg uCycReg (
    .clk     (clk),
    .rst     (rst),
    .load    (load),
    .cycNext (cycNext),
    .cyc     (reqCyc),
    .hasCycle(hasCycle)
  );

  vmaContext uContext (
    .clk       (clk),
    .rst       (rst),
    .load      (load),
    .func      (func),
    .stepMagic (stepMagic),
    .stepAd    (stepAd),
    .userMode  (userMode),
    .publicMode(publicMode),
    .pxctEn    (pxctEn),
    .prevUser  (prevUser),
    .reqAddr   (reqAddr),
    .reqCtx    (reqCtx),
    .reqAdrErr (reqAdrErr)
  );

  mboxRequester uRequester (
    .clk      (clk),
    .rst      (rst),
    .stepValid(stepValid),
    .stepReady(stepReady),
    .load     (load),
    .hasCycle (hasCycle),
    .cyc      (reqCyc),
    .reqCtx   (reqCtx),
    .reqAdrErr(reqAdrErr),
    .reqValid (reqValid),
    .reqReady (reqReady),
    .diagSel  (diagSel),
    .diagData (diagData)
  );

endmodule

/* tb/memCtlTb.sv */
`timescale 1ns/1ps
`include "memCtl_settings.svh"

module memCtlTb
  import uCodePkg::*;
  import memReqPkg::*;
();

  typedef struct packed {
    addr_t     addr;
    cycFlags_t cyc;
    ctxFlags_t ctx;
    logic      adrErr;
  } expReq_t;

  logic       clk = 1'b0;
  logic       rst;
  logic       stepValid;
  logic       stepReady;
  memField_t  stepMem;
  magic_t     stepMagic;
  drmA_t      stepDrmA;
  addr_t      stepAd;
  logic       userMode;
  logic       publicMode;
  logic       pxctEn;
  logic       prevUser;
  logic       reqValid;
  logic       reqReady = 1'b0;
  addr_t      reqAddr;
  cycFlags_t  reqCyc;
  ctxFlags_t  reqCtx;
  logic       reqAdrErr;
  logic [1:0] diagSel = 2'd0;
  logic [3:0] diagData;

  integer    seed = 50;
  expReq_t   expQ[$];
  logic      monOn = 1'b0;
  logic      nextReady = 1'b1;
  int        readyMode = 0;
  int        readyLeft = 0;
  int        reqCount = 0;
  cycFlags_t heldCyc = '0;
  ctxFlags_t heldCtx = '0;
  logic      heldErr = 1'b0;

  memCtl dut (
    .clk(clk), .rst(rst), .stepValid(stepValid), .stepReady(stepReady),
    .stepMem(stepMem), .stepMagic(stepMagic), .stepDrmA(stepDrmA), .stepAd(stepAd),
    .userMode(userMode), .publicMode(publicMode), .pxctEn(pxctEn), .prevUser(prevUser),
    .reqValid(reqValid), .reqReady(reqReady), .reqAddr(reqAddr), .reqCyc(reqCyc),
    .reqCtx(reqCtx), .reqAdrErr(reqAdrErr), .diagSel(diagSel), .diagData(diagData)
  );

  always #5 clk = ~clk;

  task automatic failRun(input string msg);
    $display("%s", msg);
    $display("Result: FAILED");
    $fatal(1, "stopping at first error");
  endtask

  task automatic checkVal(input string name, input logic [31:0] act, input logic [31:0] exp);
    if (act !== exp) begin
      failRun($sformatf("mismatch %s: got 0x%0h expected 0x%0h", name, act, exp));
    end
  endtask

  // Expected request of one step, straight from the decode and context rules
  function automatic expReq_t refCycle(input memField_t mem, input magic_t magic,
      input drmA_t drmA, input addr_t ad, input logic [3:0] modes);
    expReq_t  e;
    memFunc_e f;
    logic     ld, ldx, ps, wr, ft, prev, usr, ext;
    section_t sect;
    f = memFunc_e'(mem);
    ft = (f == uncondFetch) || (f == condFetch && magic[5]);
    ld = (f == loadAr) || (f == rwCycle) || (f == rpwCycle) || (f == aRead && drmA[2]);
    ldx = (f == loadArx) || ft;
    ps = (f == rpwCycle) || (f == aRead && drmA == 3'd7);
    wr = (f == write) || (f == rwCycle) || (f == rpwCycle) || (f == bWrite) ||
         (f == aRead && (drmA == 3'd3 || drmA == 3'd6 || drmA == 3'd7));
    if (f == eaCalc) begin
      ld = ld | magic[3];
      ldx = ldx | magic[2];
      ps = ps | magic[1];
      wr = wr | magic[0];
    end
    // modes is {userMode, publicMode, pxctEn, prevUser}
    prev = modes[1] && (f == eaCalc) && magic[5];
    usr = prev ? modes[0] : modes[3];
    sect = ad[`ADDR_W-1 -: `SECT_W];
    ext = (sect != '0) && (f == eaCalc || f == aRead);
    e.addr = ad;
    e.cyc = {ld, ldx, ps, wr, ft};
    e.ctx = {usr, modes[2] && !usr, prev, ext};
    e.adrErr = ext && (int'(sect) > `MAX_SECTION);
    return e;
  endfunction

  // Entered and left 1 ns after a rising edge
  task automatic sendStep(input memField_t mem, input magic_t magic, input drmA_t drmA,
      input addr_t ad, input logic [3:0] modes);
    int      waitCnt;
    expReq_t e;
    stepValid = 1'b1;
    stepMem = mem;
    stepMagic = magic;
    stepDrmA = drmA;
    stepAd = ad;
    {userMode, publicMode, pxctEn, prevUser} = modes;
    waitCnt = 0;
    @(negedge clk);
    while (!stepReady) begin
      waitCnt++;
      if (waitCnt > 200) failRun("timeout: step was never accepted");
      @(negedge clk);
    end
    e = refCycle(mem, magic, drmA, ad, modes);
    @(posedge clk);
    // Accepted at this edge
    if (e.cyc != '0) expQ.push_back(e);
    #1;
  endtask

  task automatic randStep(input memField_t mem, input drmA_t drmA, input section_t sect);
    logic [31:0] r;
    r = $random(seed);
    sendStep(mem, r[`MAGIC_W-1:0], drmA, {sect, r[`ADDR_W-`SECT_W-1+9:9]}, r[31:28]);
  endtask

  // Back-pressure stretches chosen at the falling edge
  always @(negedge clk) begin
    logic [31:0] r;
    if (readyMode == 0) begin
      nextReady = 1'b1;
    end else if (readyLeft == 0) begin
      r = $random(seed);
      nextReady = r[0] | ((readyMode == 1) & r[1]);
      readyLeft = (readyMode == 2) ? int'(r[7:4]) : int'(r[5:4]);
    end else begin
      readyLeft = readyLeft - 1;
    end
  end

  always @(posedge clk) begin
    #1;
    reqReady = nextReady;
    diagSel = diagSel + 2'd1;
  end

  always @(negedge clk) begin
    logic [3:0] diagExp;
    logic       pend;
    if (monOn) begin
      // One request in flight, so the queue head is the pending one
      pend = (expQ.size() != 0);
      checkVal("reqValid", 32'(reqValid), 32'(pend));
      checkVal("stepReady", 32'(stepReady), 32'(!pend || reqReady));
      case (diagSel)
        2'd0: diagExp = heldCyc[3:0];
        2'd1: diagExp = heldCtx;
        2'd2: diagExp = {heldCyc[0], heldErr, 2'b00};
        default: diagExp = 4'b0000;
      endcase
      checkVal("diagData", 32'(diagData), 32'(diagExp));
      if (pend) begin
        checkVal("reqAddr", 32'(reqAddr), 32'(expQ[0].addr));
        checkVal("reqCyc", 32'(reqCyc), 32'(expQ[0].cyc));
        checkVal("reqCtx", 32'(reqCtx), 32'(expQ[0].ctx));
        checkVal("reqAdrErr", 32'(reqAdrErr), 32'(expQ[0].adrErr));
        if (reqReady) begin
          // Held register takes these at the coming edge
          heldCyc = expQ[0].cyc;
          heldCtx = expQ[0].ctx;
          heldErr = expQ[0].adrErr;
          void'(expQ.pop_front());
          reqCount++;
        end
      end
    end
  end

  initial begin
    int          m, d, k, drain;
    logic [31:0] r;
    memField_t   mem;
    section_t    sect;
    rst = 1'b1;
    stepValid = 1'b0;
    stepMem = '0;
    stepMagic = '0;
    stepDrmA = '0;
    stepAd = '0;
    {userMode, publicMode, pxctEn, prevUser} = 4'b0000;
    repeat (4) @(posedge clk);
    #1;
    rst = 1'b0;
    @(negedge clk);
    checkVal("reqValid", 32'(reqValid), 32'd0);
    checkVal("stepReady", 32'(stepReady), 32'd1);
    monOn = 1'b1;
    @(posedge clk);
    #1;

    // Every function against every dispatch A value
    readyMode = 1;
    for (m = 0; m < 16; m++) begin
      for (d = 0; d < 8; d++) begin
        r = $random(seed);
        randStep(memField_t'(m), drmA_t'(d), r[5:0]);
      end
    end

    // Context mostly from EA calc and A read
    for (k = 0; k < 200; k++) begin
      r = $random(seed);
      if (r[4]) mem = r[5] ? memField_t'(eaCalc) : memField_t'(aRead);
      else mem = r[3:0];
      randStep(mem, r[8:6], r[14:9]);
    end

    // Sections around the legal limit
    for (k = 0; k < 16; k++) begin
      case (k % 4)
        0: sect = 6'd0;
        1: sect = 6'd31;
        2: sect = 6'd32;
        default: sect = 6'd63;
      endcase
      r = $random(seed);
      if (k < 8) begin
        sendStep(memField_t'(eaCalc), r[8:0] | 9'h008, 3'd0, {sect, r[17:0]}, r[31:28]);
      end else begin
        sendStep(memField_t'(aRead), r[8:0], {1'b1, r[25:24]}, {sect, r[17:0]}, r[31:28]);
      end
    end

    // Long back-pressure with back-to-back steps
    readyMode = 2;
    for (k = 0; k < 150; k++) begin
      r = $random(seed);
      randStep(r[3:0], r[6:4], r[12:7]);
    end

    stepValid = 1'b0;
    drain = 0;
    while (expQ.size() != 0 && drain < 500) begin
      @(posedge clk);
      drain++;
    end
    @(negedge clk);
    checkVal("reqValid", 32'(reqValid), 32'd0);
    $display("%0d memory requests checked", reqCount);
    if (expQ.size() != 0) begin
      failRun("timeout: expected requests never reached the memory side");
    end else begin
      $display("Result: PASSED");
      $finish;
    end
  end

endmodule

/* build.f */
+incdir+include
logic/uCodePkg.sv
logic/memReqPkg.sv
logic/memFuncDecode.sv
logic/cycleTypeReg.sv
logic/vmaContext.sv
logic/mboxRequester.sv
logic/memCtl.sv
tb/memCtlTb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the memCtl testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --timescale 1ns/1ps -f build.f \
  --top-module memCtlTb -Mdir obj_dir -o memCtlSim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/memCtlSim > "$LOG" 2>&1
simStatus=$?
cat "$LOG"
if [ $simStatus -ne 0 ]; then
  echo "Simulation exited with status $simStatus"
fi

if grep -qx "Result: PASSED" "$LOG"; then
  exit 0
fi
echo "Pass message not found in $LOG"
exit 1
